// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard source/*.sv test/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== rv_core.f ====
source/core_pkg.sv
source/register_file.sv
source/decode_stage.sv
source/operand_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/writeback_stage.sv
source/rv_core.sv
test/tb_clock.sv
test/rv_core_tb.sv

// ==== source/core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int    REG_COUNT  = 32;
    localparam int    GP_REG     = 3;
    localparam inst_t EXIT_INST  = 32'h0000_0073;
    localparam addr_t INST_BYTES = 32'd4;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY2
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
    } br_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;
    typedef enum logic       {OP2_RS2, OP2_IMM} op2_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

    // all-zero decodes to a no-op
    typedef struct packed {
        alu_op_e   alu_op;
        br_op_e    br_op;
        op1_sel_e  op1_sel;
        op2_sel_e  op2_sel;
        logic      mem_ren;
        logic      mem_wen;
        logic      rf_wen;
        wb_sel_e   wb_sel;
        reg_addr_t wb_addr;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      is_exit;
        logic      uses_rs1;
        logic      uses_rs2;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        ctrl_t ctrl;
        xlen_t imm;
    } ds_in_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        ctrl_t ctrl;
        xlen_t op1;
        xlen_t op2;
        xlen_t rs1_data;
        xlen_t rs2_data;
        xlen_t imm;
    } exe_in_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        ctrl_t ctrl;
        xlen_t alu_out;
        xlen_t rs2_data;
    } mem_in_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        ctrl_t ctrl;
        xlen_t alu_out;
        xlen_t mem_rdata;
    } wb_in_t;

    typedef struct packed {
        logic      valid;
        logic      can_forward;
        reg_addr_t addr;
        xlen_t     wdata;
    } fwd_t;

    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

endpackage

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n_i,
    input  logic   inst_valid_i,
    input  addr_t  inst_pc_i,
    input  inst_t  inst_i,
    input  logic   stall_i,
    input  logic   flush_i,
    output logic   inst_ready_o,
    output ds_in_t ds_o
);

    logic       id_valid;
    addr_t      id_pc;
    inst_t      id_inst;
    logic       hold;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub_ok,
                                           input logic alt_bit);
        case (f3)
            3'b000:  return (sub_ok && alt_bit) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt_bit ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign hold         = stall_i && id_valid;
    assign inst_ready_o = !hold;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_valid <= 1'b0;
            id_pc    <= '0;
            id_inst  <= '0;
        end else if (flush_i) begin
            // the redirect cycle drops whatever fetch offers
            id_valid <= 1'b0;
        end else if (!hold) begin
            id_valid <= inst_valid_i;
            id_pc    <= inst_pc_i;
            id_inst  <= inst_i;
        end
    end

    assign opcode = id_inst[6:0];
    assign funct3 = id_inst[14:12];
    assign alt    = id_inst[30];

    always_comb begin
        ds_o.valid        = id_valid;
        ds_o.pc           = id_pc;
        ds_o.imm          = '0;
        ds_o.ctrl         = '0;
        ds_o.ctrl.wb_addr = id_inst[11:7];
        ds_o.ctrl.rs1     = id_inst[19:15];
        ds_o.ctrl.rs2     = id_inst[24:20];
        case (opcode)
            OPC_OP: begin
                ds_o.ctrl.alu_op   = alu_decode(funct3, 1'b1, alt);
                ds_o.ctrl.rf_wen   = 1'b1;
                ds_o.ctrl.uses_rs1 = 1'b1;
                ds_o.ctrl.uses_rs2 = 1'b1;
            end
            OPC_OP_IMM: begin
                ds_o.ctrl.alu_op   = alu_decode(funct3, 1'b0, alt);
                ds_o.ctrl.op2_sel  = OP2_IMM;
                ds_o.ctrl.rf_wen   = 1'b1;
                ds_o.ctrl.uses_rs1 = 1'b1;
                ds_o.imm           = {{20{id_inst[31]}}, id_inst[31:20]};
            end
            OPC_LUI, OPC_AUIPC: begin
                ds_o.ctrl.op1_sel = (opcode == OPC_LUI) ? OP1_ZERO : OP1_PC;
                ds_o.ctrl.op2_sel = OP2_IMM;
                ds_o.ctrl.rf_wen  = 1'b1;
                ds_o.imm          = {id_inst[31:12], 12'b0};
            end
            OPC_BRANCH: begin
                ds_o.ctrl.op1_sel  = OP1_PC;
                ds_o.ctrl.uses_rs1 = 1'b1;
                ds_o.ctrl.uses_rs2 = 1'b1;
                ds_o.imm = {{19{id_inst[31]}}, id_inst[31], id_inst[7],
                            id_inst[30:25], id_inst[11:8], 1'b0};
                case (funct3)
                    3'b000:  ds_o.ctrl.br_op = BR_EQ;
                    3'b001:  ds_o.ctrl.br_op = BR_NE;
                    3'b100:  ds_o.ctrl.br_op = BR_LT;
                    3'b101:  ds_o.ctrl.br_op = BR_GE;
                    3'b110:  ds_o.ctrl.br_op = BR_LTU;
                    3'b111:  ds_o.ctrl.br_op = BR_GEU;
                    default: ds_o.ctrl.br_op = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                ds_o.ctrl.br_op   = BR_JUMP;
                ds_o.ctrl.op1_sel = OP1_PC;
                ds_o.ctrl.rf_wen  = 1'b1;
                ds_o.ctrl.wb_sel  = WB_PC4;
                ds_o.imm = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12],
                            id_inst[20], id_inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                ds_o.ctrl.br_op    = BR_JUMP;
                ds_o.ctrl.rf_wen   = 1'b1;
                ds_o.ctrl.wb_sel   = WB_PC4;
                ds_o.ctrl.uses_rs1 = 1'b1;
                ds_o.imm           = {{20{id_inst[31]}}, id_inst[31:20]};
            end
            OPC_LOAD: begin
                ds_o.ctrl.op2_sel  = OP2_IMM;
                ds_o.ctrl.mem_ren  = 1'b1;
                ds_o.ctrl.rf_wen   = 1'b1;
                ds_o.ctrl.wb_sel   = WB_MEM;
                ds_o.ctrl.uses_rs1 = 1'b1;
                ds_o.imm           = {{20{id_inst[31]}}, id_inst[31:20]};
            end
            OPC_STORE: begin
                ds_o.ctrl.op2_sel  = OP2_IMM;
                ds_o.ctrl.mem_wen  = 1'b1;
                ds_o.ctrl.uses_rs1 = 1'b1;
                ds_o.ctrl.uses_rs2 = 1'b1;
                ds_o.imm = {{20{id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
            end
            OPC_SYSTEM: ds_o.ctrl.is_exit = (id_inst == EXIT_INST);
            default: ;
        endcase
    end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  exe_in_t   exe_i,
    output fwd_t      exe_fwd_o,
    output mem_in_t   mem_o,
    output redirect_t redirect_o,
    output logic      flush_o
);

    exe_in_t   exe_q;
    redirect_t redirect_q;
    xlen_t     alu_out;
    logic      cond;
    logic      taken;
    addr_t     target;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exe_q <= '0;
        end else begin
            exe_q <= exe_i;
        end
    end

    always_comb begin
        case (exe_q.ctrl.alu_op)
            ALU_ADD:   alu_out = exe_q.op1 + exe_q.op2;
            ALU_SUB:   alu_out = exe_q.op1 - exe_q.op2;
            ALU_SLL:   alu_out = exe_q.op1 << exe_q.op2[4:0];
            ALU_SLT:   alu_out = {31'b0, $signed(exe_q.op1) < $signed(exe_q.op2)};
            ALU_SLTU:  alu_out = {31'b0, exe_q.op1 < exe_q.op2};
            ALU_XOR:   alu_out = exe_q.op1 ^ exe_q.op2;
            ALU_SRL:   alu_out = exe_q.op1 >> exe_q.op2[4:0];
            ALU_SRA:   alu_out = xlen_t'($signed(exe_q.op1) >>> exe_q.op2[4:0]);
            ALU_OR:    alu_out = exe_q.op1 | exe_q.op2;
            ALU_AND:   alu_out = exe_q.op1 & exe_q.op2;
            ALU_COPY2: alu_out = exe_q.op2;
            default:   alu_out = '0;
        endcase
    end

    always_comb begin
        case (exe_q.ctrl.br_op)
            BR_EQ:   cond = exe_q.rs1_data == exe_q.rs2_data;
            BR_NE:   cond = exe_q.rs1_data != exe_q.rs2_data;
            BR_LT:   cond = $signed(exe_q.rs1_data) < $signed(exe_q.rs2_data);
            BR_GE:   cond = $signed(exe_q.rs1_data) >= $signed(exe_q.rs2_data);
            BR_LTU:  cond = exe_q.rs1_data < exe_q.rs2_data;
            BR_GEU:  cond = exe_q.rs1_data >= exe_q.rs2_data;
            BR_JUMP: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    // op1 is pc for branches and jal, rs1 for jalr
    assign target = (exe_q.op1 + exe_q.imm) & ~addr_t'(1);
    assign taken  = exe_q.valid && cond;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            redirect_q <= '0;
        end else begin
            redirect_q.valid  <= taken;
            redirect_q.target <= target;
        end
    end

    assign redirect_o = redirect_q;
    assign flush_o    = taken || redirect_q.valid;

    // only used to hold operand select back
    assign exe_fwd_o.valid       = exe_q.valid && exe_q.ctrl.rf_wen;
    assign exe_fwd_o.can_forward = 1'b0;
    assign exe_fwd_o.addr        = exe_q.ctrl.wb_addr;
    assign exe_fwd_o.wdata       = alu_out;

    assign mem_o.valid    = exe_q.valid;
    assign mem_o.pc       = exe_q.pc;
    assign mem_o.ctrl     = exe_q.ctrl;
    assign mem_o.alu_out  = alu_out;
    assign mem_o.rs2_data = exe_q.rs2_data;

endmodule

// ==== source/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  mem_in_t mem_i,
    input  xlen_t   dmem_rdata_i,
    output logic    dmem_valid_o,
    output logic    dmem_wen_o,
    output addr_t   dmem_addr_o,
    output xlen_t   dmem_wdata_o,
    output fwd_t    mem_fwd_o,
    output wb_in_t  wb_o
);

    mem_in_t mem_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_q <= '0;
        end else begin
            mem_q <= mem_i;
        end
    end

    assign dmem_valid_o = mem_q.valid && (mem_q.ctrl.mem_ren || mem_q.ctrl.mem_wen);
    assign dmem_wen_o   = mem_q.valid && mem_q.ctrl.mem_wen;
    assign dmem_addr_o  = mem_q.alu_out;
    assign dmem_wdata_o = mem_q.rs2_data;

    // load data is not ready to forward until writeback
    assign mem_fwd_o.valid       = mem_q.valid && mem_q.ctrl.rf_wen;
    assign mem_fwd_o.can_forward = !mem_q.ctrl.mem_ren;
    assign mem_fwd_o.addr        = mem_q.ctrl.wb_addr;
    assign mem_fwd_o.wdata       = (mem_q.ctrl.wb_sel == WB_PC4) ? mem_q.pc + INST_BYTES
                                                                  : mem_q.alu_out;

    assign wb_o.valid     = mem_q.valid;
    assign wb_o.pc        = mem_q.pc;
    assign wb_o.ctrl      = mem_q.ctrl;
    assign wb_o.alu_out   = mem_q.alu_out;
    assign wb_o.mem_rdata = dmem_rdata_i;

endmodule

// ==== source/operand_stage.sv ====
`timescale 1ns/1ps

module operand_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  ds_in_t    ds_i,
    input  logic      flush_i,
    input  fwd_t      exe_fwd_i,
    input  fwd_t      mem_fwd_i,
    input  fwd_t      wb_fwd_i,
    input  xlen_t     rs1_data_i,
    input  xlen_t     rs2_data_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output logic      stall_o,
    output exe_in_t   exe_o
);

    ds_in_t ds_q;
    xlen_t  rs1_val;
    xlen_t  rs2_val;
    logic   rs1_wait;
    logic   rs2_wait;

    // mem holds the younger result, so it is checked first
    function automatic xlen_t pick(input reg_addr_t addr, input xlen_t rf_data,
                                   input fwd_t mem_fwd, input fwd_t wb_fwd);
        if (addr == '0) return '0;
        if (mem_fwd.valid && mem_fwd.can_forward && mem_fwd.addr == addr) begin
            return mem_fwd.wdata;
        end
        if (wb_fwd.valid && wb_fwd.can_forward && wb_fwd.addr == addr) begin
            return wb_fwd.wdata;
        end
        return rf_data;
    endfunction

    function automatic logic blocked(input logic used, input reg_addr_t addr,
                                     input fwd_t src);
        return used && addr != '0 && src.valid && !src.can_forward && src.addr == addr;
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ds_q <= '0;
        end else if (flush_i) begin
            ds_q.valid <= 1'b0;
        end else if (!stall_o) begin
            ds_q <= ds_i;
        end
    end

    assign rs1_addr_o = ds_q.ctrl.rs1;
    assign rs2_addr_o = ds_q.ctrl.rs2;

    always_comb begin
        rs1_val  = pick(ds_q.ctrl.rs1, rs1_data_i, mem_fwd_i, wb_fwd_i);
        rs2_val  = pick(ds_q.ctrl.rs2, rs2_data_i, mem_fwd_i, wb_fwd_i);
        rs1_wait = blocked(ds_q.ctrl.uses_rs1, ds_q.ctrl.rs1, exe_fwd_i)
                || blocked(ds_q.ctrl.uses_rs1, ds_q.ctrl.rs1, mem_fwd_i);
        rs2_wait = blocked(ds_q.ctrl.uses_rs2, ds_q.ctrl.rs2, exe_fwd_i)
                || blocked(ds_q.ctrl.uses_rs2, ds_q.ctrl.rs2, mem_fwd_i);
    end

    assign stall_o = ds_q.valid && (rs1_wait || rs2_wait);

    always_comb begin
        // a stalled slot leaves a bubble behind it
        exe_o.valid    = ds_q.valid && !stall_o && !flush_i;
        exe_o.pc       = ds_q.pc;
        exe_o.ctrl     = ds_q.ctrl;
        exe_o.rs1_data = rs1_val;
        exe_o.rs2_data = rs2_val;
        exe_o.imm      = ds_q.imm;
        case (ds_q.ctrl.op1_sel)
            OP1_PC:   exe_o.op1 = ds_q.pc;
            OP1_ZERO: exe_o.op1 = '0;
            default:  exe_o.op1 = rs1_val;
        endcase
        exe_o.op2 = (ds_q.ctrl.op2_sel == OP2_IMM) ? ds_q.imm : rs2_val;
    end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps

module register_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  logic      wen_i,
    input  reg_addr_t waddr_i,
    input  xlen_t     wdata_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    output xlen_t     gp_o
);

    xlen_t regs [REG_COUNT];

    // same-cycle write is visible to the reader
    function automatic xlen_t read_port(input reg_addr_t addr, input logic wen,
                                        input reg_addr_t waddr, input xlen_t wdata);
        if (addr == '0) return '0;
        if (wen && waddr == addr) return wdata;
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i, wen_i, waddr_i, wdata_i);
        rs2_data_o = read_port(rs2_addr_i, wen_i, waddr_i, wdata_i);
    end

    assign gp_o = regs[GP_REG];

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import core_pkg::*; (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  inst_valid_i,
    input  addr_t inst_pc_i,
    input  inst_t inst_i,
    output logic  inst_ready_o,
    output logic  redirect_valid_o,
    output addr_t redirect_addr_o,
    output logic  dmem_valid_o,
    output logic  dmem_wen_o,
    output addr_t dmem_addr_o,
    output xlen_t dmem_wdata_o,
    input  xlen_t dmem_rdata_i,
    output logic  exit_o,
    output xlen_t gp_o
);

    ds_in_t    ds;
    exe_in_t   exe_in;
    mem_in_t   mem_in;
    wb_in_t    wb_in;
    fwd_t      exe_fwd;
    fwd_t      mem_fwd;
    fwd_t      wb_fwd;
    redirect_t redirect;
    logic      flush;
    logic      stall;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    logic      rf_wen;
    reg_addr_t rf_waddr;
    xlen_t     rf_wdata;

    assign redirect_valid_o = redirect.valid;
    assign redirect_addr_o  = redirect.target;

    decode_stage u_decode (
        .clk, .rst_n_i, .inst_valid_i, .inst_pc_i, .inst_i,
        .stall_i(stall), .flush_i(flush), .inst_ready_o, .ds_o(ds)
    );

    operand_stage u_operand (
        .clk, .rst_n_i, .ds_i(ds), .flush_i(flush),
        .exe_fwd_i(exe_fwd), .mem_fwd_i(mem_fwd), .wb_fwd_i(wb_fwd),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .stall_o(stall), .exe_o(exe_in)
    );

    register_file u_regs (
        .clk, .rst_n_i, .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .wen_i(rf_wen), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data), .gp_o
    );

    execute_stage u_execute (
        .clk, .rst_n_i, .exe_i(exe_in), .exe_fwd_o(exe_fwd), .mem_o(mem_in),
        .redirect_o(redirect), .flush_o(flush)
    );

    memory_stage u_memory (
        .clk, .rst_n_i, .mem_i(mem_in), .dmem_rdata_i,
        .dmem_valid_o, .dmem_wen_o, .dmem_addr_o, .dmem_wdata_o,
        .mem_fwd_o(mem_fwd), .wb_o(wb_in)
    );

    writeback_stage u_writeback (
        .clk, .rst_n_i, .wb_i(wb_in), .rf_wen_o(rf_wen), .rf_waddr_o(rf_waddr),
        .rf_wdata_o(rf_wdata), .wb_fwd_o(wb_fwd), .exit_o
    );

endmodule

// ==== source/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  wb_in_t    wb_i,
    output logic      rf_wen_o,
    output reg_addr_t rf_waddr_o,
    output xlen_t     rf_wdata_o,
    output fwd_t      wb_fwd_o,
    output logic      exit_o
);

    wb_in_t wb_q;
    logic   exit_q;
    logic   retire_exit;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q   <= '0;
            exit_q <= 1'b0;
        end else begin
            wb_q   <= wb_i;
            exit_q <= exit_o;
        end
    end

    assign retire_exit = wb_q.valid && wb_q.ctrl.is_exit;
    assign exit_o      = exit_q || retire_exit;

    always_comb begin
        case (wb_q.ctrl.wb_sel)
            WB_MEM:  rf_wdata_o = wb_q.mem_rdata;
            WB_PC4:  rf_wdata_o = wb_q.pc + INST_BYTES;
            default: rf_wdata_o = wb_q.alu_out;
        endcase
    end

    // nothing retires once the core has exited
    assign rf_wen_o   = wb_q.valid && wb_q.ctrl.rf_wen && !exit_q;
    assign rf_waddr_o = wb_q.ctrl.wb_addr;

    assign wb_fwd_o.valid       = rf_wen_o;
    assign wb_fwd_o.can_forward = 1'b1;
    assign wb_fwd_o.addr        = rf_waddr_o;
    assign wb_fwd_o.wdata       = rf_wdata_o;

endmodule

// ==== test/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb import core_pkg::*; ();

    localparam int    PROG_LEN    = 200;
    localparam int    IDLE_CYCLES = 3;
    localparam int    TIMEOUT     = 5000;
    localparam int    MODEL_STEPS = 1000;
    localparam addr_t DATA_BASE   = 32'h0000_1000;
    localparam inst_t ECALL       = 32'h0000_0073;
    localparam inst_t NOP         = 32'h0000_0013;

    logic  clk;
    logic  rst_n_i;
    logic  inst_valid_i;
    addr_t inst_pc_i;
    inst_t inst_i;
    logic  inst_ready_o;
    logic  redirect_valid_o;
    addr_t redirect_addr_o;
    logic  dmem_valid_o;
    logic  dmem_wen_o;
    addr_t dmem_addr_o;
    xlen_t dmem_wdata_o;
    xlen_t dmem_rdata_i;
    logic  exit_o;
    xlen_t gp_o;

    inst_t prog [1024];
    xlen_t dmem [64];
    xlen_t model_mem [64];
    xlen_t model_regs [32];
    addr_t store_addr_q [$];
    xlen_t store_data_q [$];
    addr_t target_q [$];

    addr_t     fetch_pc;
    reg_addr_t last_rd;
    int        cycle;
    int        n_store;
    int        n_redirect;
    logic      consumed_any;
    logic      done;

    tb_clock u_clock (.clk_o(clk));

    rv_core dut (.*);

    // combinational read port
    assign dmem_rdata_i = dmem[dmem_addr_o[7:2]];

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            $display("** Error: %s: expected %h, actual %h", name, expected, actual);
            fail_run("value mismatch");
        end
    endtask

    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // pattern spread over the whole byte address
    function automatic xlen_t fill_word(input int idx);
        addr_t a;
        a = DATA_BASE + addr_t'(4 * idx);
        return {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    // x30 and x31 stay reserved for jalr and the data base
    function automatic reg_addr_t dest_reg();
        return reg_addr_t'($urandom_range(29, 1));
    endfunction

    // half the time reuse the last result to provoke hazards
    function automatic reg_addr_t source_reg();
        if ($urandom_range(1, 0) == 1) return last_rd;
        return reg_addr_t'($urandom_range(31, 0));
    endfunction

    task automatic build_program();
        int          i;
        int          kind;
        int          skip;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [20:0] off;
        logic        landing [1024];
        for (i = 0; i < 1024; i++) begin
            prog[i]    = NOP;
            landing[i] = 1'b0;
        end
        for (i = 0; i < 64; i++) begin
            dmem[i]      = fill_word(i);
            model_mem[i] = fill_word(i);
            if (i < 32) model_regs[i] = '0;
        end
        // lui x31 with the data base
        prog[0] = {DATA_BASE[31:12], 5'd31, OPC_LUI};
        i = 1;
        last_rd = '0;
        while (i < PROG_LEN - 1) begin
            rd   = dest_reg();
            rs1  = source_reg();
            rs2  = source_reg();
            f3   = 3'($urandom_range(7, 0));
            alt  = 1'($urandom_range(1, 0));
            kind = $urandom_range(9, 0);
            skip = $urandom_range(3, 0);
            // control flow must land at or before the ecall
            if (kind >= 7 && i + skip + 3 >= PROG_LEN - 1) kind = 0;
            // a jalr entered without its auipc has no known base
            if (kind == 9 && landing[i + 1]) kind = 0;
            case (kind)
                0, 1: begin
                    imm = ((f3 == 3'd0 || f3 == 3'd5) && alt) ? 12'h400 : 12'h000;
                    prog[i] = {imm[11:5], rs2, rs1, f3, rd, OPC_OP};
                end
                2, 3: begin
                    imm = 12'($urandom_range(4095, 0));
                    if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
                    if (f3 == 3'd5) imm = {1'b0, alt, 5'h00, imm[4:0]};
                    prog[i] = {imm, rs1, f3, rd, OPC_OP_IMM};
                end
                4: prog[i] = {20'($urandom), rd, alt ? OPC_AUIPC : OPC_LUI};
                5: begin
                    off = 21'(4 * $urandom_range(63, 0));
                    prog[i] = {off[11:0], 5'd31, 3'b010, rd, OPC_LOAD};
                end
                6: begin
                    off = 21'(4 * $urandom_range(63, 0));
                    prog[i] = {off[11:5], rs2, 5'd31, 3'b010, off[4:0], OPC_STORE};
                end
                7: begin
                    if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
                    off = 21'(4 * (skip + 1));
                    prog[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
                end
                8: begin
                    off = 21'(4 * (skip + 1));
                    prog[i] = {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
                end
                default: begin
                    // auipc x30 then jalr relative to it
                    prog[i] = {20'h00000, 5'd30, OPC_AUIPC};
                    i++;
                    off = 21'(4 * (skip + 2));
                    prog[i] = {off[11:0], 5'd30, 3'b000, rd, OPC_JALR};
                end
            endcase
            if (kind >= 7) landing[i + skip + 1] = 1'b1;
            if (kind != 6 && kind != 7) last_rd = rd;
            i++;
        end
        prog[i] = ECALL;
    endtask

    task automatic run_model();
        addr_t pc;
        addr_t next;
        inst_t w;
        xlen_t a;
        xlen_t b;
        xlen_t res;
        xlen_t iimm;
        xlen_t uimm;
        logic  wr;
        logic  taken;
        int    steps;
        pc    = '0;
        steps = 0;
        while (prog[pc[11:2]] != ECALL && steps < MODEL_STEPS) begin
            w     = prog[pc[11:2]];
            a     = model_regs[w[19:15]];
            b     = model_regs[w[24:20]];
            iimm  = {{20{w[31]}}, w[31:20]};
            uimm  = {w[31:12], 12'h000};
            next  = pc + 32'd4;
            res   = '0;
            wr    = 1'b1;
            taken = 1'b0;
            case (w[6:0])
                OPC_OP:     res = alu_ref(w[14:12], w[30], a, b);
                OPC_OP_IMM: res = alu_ref(w[14:12], w[14:12] == 3'b101 && w[30], a, iimm);
                OPC_LUI:    res = uimm;
                OPC_AUIPC:  res = pc + uimm;
                OPC_LOAD:   res = model_mem[6'((a + iimm - DATA_BASE) >> 2)];
                OPC_JAL: begin
                    res   = pc + 32'd4;
                    taken = 1'b1;
                    next  = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                OPC_JALR: begin
                    res   = pc + 32'd4;
                    taken = 1'b1;
                    next  = (a + iimm) & ~32'd1;
                end
                OPC_BRANCH: begin
                    wr    = 1'b0;
                    taken = branch_ref(w[14:12], a, b);
                    if (taken) next = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
                OPC_STORE: begin
                    wr = 1'b0;
                    store_addr_q.push_back(a + {{20{w[31]}}, w[31:25], w[11:7]});
                    store_data_q.push_back(b);
                    model_mem[6'((store_addr_q[$] - DATA_BASE) >> 2)] = b;
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 5'd0) model_regs[w[11:7]] = res;
            if (taken) target_q.push_back(next);
            pc = next;
            steps++;
        end
        if (steps >= MODEL_STEPS) fail_run("reference model never reached the ecall");
    endtask

    task automatic watch_outputs();
        if (!consumed_any) begin
            check_value("idle redirect_valid_o", '0, xlen_t'(redirect_valid_o));
            check_value("idle dmem_valid_o", '0, xlen_t'(dmem_valid_o));
            check_value("idle exit_o", '0, xlen_t'(exit_o));
        end
        if (redirect_valid_o) begin
            if (n_redirect >= target_q.size()) begin
                fail_run("redirect without a taken branch in the reference model");
            end else begin
                check_value("redirect target", target_q[n_redirect], redirect_addr_o);
                n_redirect++;
            end
        end
        if (dmem_valid_o && (dmem_addr_o[31:8] != DATA_BASE[31:8] || dmem_addr_o[1:0] != 2'b00))
        begin
            fail_run("data access outside the data region");
        end else if (dmem_valid_o && dmem_wen_o) begin
            if (n_store >= store_addr_q.size()) begin
                fail_run("more stores than the reference model made");
            end else begin
                check_value("store address", store_addr_q[n_store], dmem_addr_o);
                check_value("store data", store_data_q[n_store], dmem_wdata_o);
                dmem[dmem_addr_o[7:2]] = dmem_wdata_o;
                n_store++;
            end
        end
    endtask

    // decides now whether the coming edge consumes the word
    task automatic drive_fetch();
        if (redirect_valid_o) begin
            fetch_pc     = redirect_addr_o;
            inst_valid_i = 1'b0;
        end else begin
            inst_valid_i = (cycle > IDLE_CYCLES) && ($urandom_range(3, 0) != 0);
            inst_pc_i    = fetch_pc;
            inst_i       = prog[fetch_pc[11:2]];
            if (inst_valid_i && inst_ready_o) begin
                fetch_pc     = fetch_pc + 32'd4;
                consumed_any = 1'b1;
            end
        end
    endtask

    initial begin
        void'($urandom(32'hbb18));
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_pc_i    = '0;
        inst_i       = '0;
        fetch_pc     = '0;
        cycle        = 0;
        n_store      = 0;
        n_redirect   = 0;
        consumed_any = 1'b0;
        done         = 1'b0;
        build_program();
        run_model();
        repeat (5) @(negedge clk);
        rst_n_i = 1'b1;
        while (!done) begin
            @(negedge clk);
            cycle++;
            if (cycle > TIMEOUT) begin
                fail_run("timed out waiting for exit_o");
            end else begin
                watch_outputs();
                if (exit_o) begin
                    done = 1'b1;
                end else begin
                    drive_fetch();
                end
            end
        end
        check_value("exit gp_o", model_regs[GP_REG], gp_o);
        check_value("store count", xlen_t'(store_addr_q.size()), xlen_t'(n_store));
        check_value("redirect count", xlen_t'(target_q.size()), xlen_t'(n_redirect));
        $display("Test OK");
        $finish;
    end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;
        end
    end

endmodule
